// File: logic/cart_pkg.sv
package cart_pkg;

    // Bus and field widths
    typedef logic [7:0]  byte_t;
    typedef logic [23:0] rom_addr_t;
    typedef logic [3:0]  size_code_t;
    typedef logic [7:0]  rom_type_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Byte positions inside the 64-byte internal header
    localparam logic [5:0] hdr_map_off      = 6'h15;
    localparam logic [5:0] hdr_type_off     = 6'h16;
    localparam logic [5:0] hdr_rom_size_off = 6'h17;
    localparam logic [5:0] hdr_ram_size_off = 6'h18;
    localparam logic [5:0] hdr_company_off  = 6'h1A;
    localparam logic [5:0] hdr_classify_off = 6'h20;
    localparam logic [5:0] hdr_last_off     = 6'h3F;
    localparam int unsigned hdr_len         = 64;

    // Register map
    localparam apb_addr_t reg_ctrl     = 8'h00;
    localparam apb_addr_t reg_hdr_base = 8'h04;
    localparam apb_addr_t reg_status   = 8'h08;
    localparam apb_addr_t reg_info     = 8'h0C;
    localparam apb_addr_t reg_rom_mask = 8'h10;
    localparam apb_addr_t reg_ram_mask = 8'h14;

    // Upper nibble of rom_type per coprocessor
    localparam logic [3:0] copro_cx4     = 4'h4;
    localparam logic [3:0] copro_sdd1    = 4'h5;
    localparam logic [3:0] copro_sa1     = 4'h6;
    localparam logic [3:0] copro_gsu     = 4'h7;
    localparam logic [3:0] copro_dsp1    = 4'h8;
    localparam logic [3:0] copro_dsp2    = 4'h9;
    localparam logic [3:0] copro_dsp3    = 4'hA;
    localparam logic [3:0] copro_dsp4    = 4'hB;
    localparam logic [3:0] copro_obc1    = 4'hC;
    localparam logic [3:0] copro_spc7110 = 4'hD;

    // SuperFX carts always see 64 KB of work RAM
    localparam rom_addr_t gsu_ram_mask = 24'h00FFFF;

endpackage

// File: logic/header_parser.sv
module header_parser #(
    // Size codes up to this value are treated as a 4 MB window
    parameter cart_pkg::size_code_t small_rom_limit = 4'd7
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  cart_pkg::byte_t      hdr_d,
    input  logic                 hdr_strb,
    output cart_pkg::rom_type_t  rom_type,
    output cart_pkg::rom_addr_t  rom_mask,
    output cart_pkg::rom_addr_t  ram_mask,
    output cart_pkg::size_code_t rom_size,
    output cart_pkg::size_code_t ram_size,
    output logic                 header_finished
);

    import cart_pkg::*;

    logic [5:0] cnt;
    byte_t      map_hdr;
    byte_t      type_hdr;
    byte_t      company_hdr;
    logic       classified;
    logic       is_gsu;

    size_code_t rom_shift;
    rom_addr_t  rom_mask_next;
    rom_addr_t  ram_mask_next;
    rom_type_t  type_next;
    logic       gsu_hit;

    // Masks follow the size codes captured so far
    always_comb begin
        rom_shift     = (rom_size <= small_rom_limit) ? 4'hC : rom_size;
        rom_mask_next = (rom_addr_t'(1024) << rom_shift) - 1'b1;
        if (is_gsu) begin
            ram_mask_next = gsu_ram_mask;
        end else if (ram_size != 4'd0) begin
            ram_mask_next = (rom_addr_t'(1024) << ram_size) - 1'b1;
        end else begin
            ram_mask_next = '0;
        end
    end

    // Mapper and coprocessor detection, first matching rule wins
    always_comb begin
        type_next = {6'b0, map_hdr[1:0]};
        gsu_hit   = 1'b0;
        if (map_hdr == 8'h30 && type_hdr == 8'h05 && company_hdr == 8'hB2) begin
            type_next[7:4] = copro_dsp3;
        end else if (((map_hdr == 8'h20 || map_hdr == 8'h21) && type_hdr == 8'h03) ||
                     (map_hdr == 8'h30 && type_hdr == 8'h05) ||
                     (map_hdr == 8'h31 && (type_hdr == 8'h03 || type_hdr == 8'h05))) begin
            // DSP1 only raises the top bit
            type_next[7] = copro_dsp1[3];
        end else if (map_hdr == 8'h20 && type_hdr == 8'h05) begin
            type_next[7:4] = copro_dsp2;
        end else if (map_hdr == 8'h30 && type_hdr == 8'h03) begin
            type_next[7:4] = copro_dsp4;
        end else if (map_hdr == 8'h30 && type_hdr == 8'h25) begin
            type_next[7:4] = copro_obc1;
        end else if (map_hdr == 8'h32 && (type_hdr == 8'h43 || type_hdr == 8'h45)) begin
            type_next[7:4] = copro_sdd1;
        end else if (map_hdr == 8'h30 && type_hdr == 8'hF6) begin
            // ST0xx family
            type_next[7:3] = 5'b10001;
            if (rom_size < 4'd10) begin
                type_next[5] = 1'b1;
            end
        end else if (map_hdr == 8'h20 && (type_hdr == 8'h13 || type_hdr == 8'h14 ||
                                          type_hdr == 8'h15 || type_hdr == 8'h1A)) begin
            type_next[7:4] = copro_gsu;
            gsu_hit        = 1'b1;
        end else if (map_hdr == 8'h23 && (type_hdr == 8'h32 || type_hdr == 8'h34 ||
                                          type_hdr == 8'h35)) begin
            type_next[7:4] = copro_sa1;
        end else if (map_hdr == 8'h3A && (type_hdr == 8'hF5 || type_hdr == 8'hF9)) begin
            type_next[7:4] = copro_spc7110;
            // Bit 3 flags the RTC variant
            type_next[3]   = type_hdr[3];
        end else if (map_hdr == 8'h20 && type_hdr == 8'hF3) begin
            type_next[7:4] = copro_cx4;
        end
    end

    // Field capture
    always_ff @(posedge clk) begin
        if (hdr_strb && !header_finished) begin
            case (cnt)
                hdr_map_off:     map_hdr     <= hdr_d;
                hdr_type_off:    type_hdr    <= hdr_d;
                hdr_company_off: company_hdr <= hdr_d;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt             <= '0;
            header_finished <= 1'b0;
            classified      <= 1'b0;
            is_gsu          <= 1'b0;
            rom_type        <= '0;
            rom_mask        <= '0;
            ram_mask        <= '0;
            rom_size        <= '0;
            ram_size        <= '0;
        end else begin
            if (hdr_strb && !header_finished) begin
                cnt      <= cnt + 1'b1;
                rom_mask <= rom_mask_next;
                ram_mask <= ram_mask_next;
                case (cnt)
                    hdr_rom_size_off: rom_size        <= hdr_d[3:0];
                    hdr_ram_size_off: ram_size        <= hdr_d[3:0];
                    hdr_last_off:     header_finished <= 1'b1;
                    default: ;
                endcase
            end
            // Classify once, after the company byte is in
            if (cnt == hdr_classify_off && !classified) begin
                classified <= 1'b1;
                rom_type   <= type_next;
                if (gsu_hit) begin
                    is_gsu   <= 1'b1;
                    ram_mask <= gsu_ram_mask;
                end
            end
        end
    end

endmodule

// File: logic/rom_loader.sv
module rom_loader #(
    // Length of the header window in bytes
    parameter int unsigned hdr_window = 64
) (
    input  logic                clk,
    input  logic                resetn,
    input  cart_pkg::byte_t     rom_d,
    input  logic                rom_strb,
    output logic                rom_ready,
    input  logic                load_en,
    input  cart_pkg::rom_addr_t hdr_base,
    output logic                mem_we,
    output cart_pkg::rom_addr_t mem_addr,
    output cart_pkg::byte_t     mem_data,
    output cart_pkg::byte_t     hdr_d,
    output logic                hdr_strb,
    output cart_pkg::rom_addr_t byte_count
);

    import cart_pkg::*;

    logic      accept;
    rom_addr_t hdr_offset;
    logic      in_window;

    // Back-pressure comes straight from the enable bit
    assign rom_ready = load_en;
    assign accept    = rom_strb && rom_ready;

    // Position of the current byte relative to the header start
    assign hdr_offset = byte_count - hdr_base;
    assign in_window  = (byte_count >= hdr_base) &&
                        (hdr_offset < rom_addr_t'(hdr_window));

    // Control and counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            byte_count <= '0;
            mem_we     <= 1'b0;
            hdr_strb   <= 1'b0;
        end else begin
            mem_we   <= accept;
            hdr_strb <= accept && in_window;
            if (accept) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    // Write payload, held between bytes
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr <= byte_count;
            mem_data <= rom_d;
            hdr_d    <= rom_d;
        end
    end

endmodule

// File: logic/cart_regs.sv
module cart_regs (
    input  logic                 clk,
    input  logic                 resetn,

    // APB3 slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  cart_pkg::apb_addr_t  paddr,
    input  cart_pkg::apb_data_t  pwdata,
    output cart_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr,

    // Loader setup
    output logic                 load_en,
    output cart_pkg::rom_addr_t  hdr_base,
    input  cart_pkg::rom_addr_t  byte_count,

    // Parser results
    input  cart_pkg::rom_type_t  rom_type,
    input  cart_pkg::rom_addr_t  rom_mask,
    input  cart_pkg::rom_addr_t  ram_mask,
    input  cart_pkg::size_code_t rom_size,
    input  cart_pkg::size_code_t ram_size,
    input  logic                 header_finished
);

    import cart_pkg::*;

    logic      access;
    logic      addr_hit;
    logic      addr_ro;
    logic      wr_en;
    apb_data_t rd_data;

    assign access = psel && penable;

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rd_data  = '0;
        case (paddr)
            reg_ctrl: begin
                rd_data = {31'd0, load_en};
            end
            reg_hdr_base: begin
                rd_data = {8'd0, hdr_base};
            end
            reg_status: begin
                addr_ro = 1'b1;
                rd_data = {byte_count, 7'd0, header_finished};
            end
            reg_info: begin
                addr_ro = 1'b1;
                rd_data = {16'd0, ram_size, rom_size, rom_type};
            end
            reg_rom_mask: begin
                addr_ro = 1'b1;
                rd_data = {8'd0, rom_mask};
            end
            reg_ram_mask: begin
                addr_ro = 1'b1;
                rd_data = {8'd0, ram_mask};
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // Zero wait states
    assign pready  = access;
    assign pslverr = access && (!addr_hit || (pwrite && addr_ro));
    assign prdata  = rd_data;

    assign wr_en = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            load_en  <= 1'b0;
            hdr_base <= '0;
        end else if (wr_en) begin
            case (paddr)
                reg_ctrl:     load_en  <= pwdata[0];
                reg_hdr_base: hdr_base <= pwdata[23:0];
                default: ;
            endcase
        end
    end

endmodule

// File: logic/cart_loader_top.sv
module cart_loader_top #(
    parameter int unsigned          hdr_window      = cart_pkg::hdr_len,
    parameter cart_pkg::size_code_t small_rom_limit = 4'd7
) (
    input  logic                clk,
    input  logic                resetn,

    // Register port
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  cart_pkg::apb_addr_t paddr,
    input  cart_pkg::apb_data_t pwdata,
    output cart_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,

    // ROM image stream
    input  cart_pkg::byte_t     rom_d,
    input  logic                rom_strb,
    output logic                rom_ready,

    // Memory writes
    output logic                mem_we,
    output cart_pkg::rom_addr_t mem_addr,
    output cart_pkg::byte_t     mem_data
);

    import cart_pkg::*;

    logic       load_en;
    rom_addr_t  hdr_base;
    rom_addr_t  byte_count;
    byte_t      hdr_d;
    logic       hdr_strb;
    rom_type_t  rom_type;
    rom_addr_t  rom_mask;
    rom_addr_t  ram_mask;
    size_code_t rom_size;
    size_code_t ram_size;
    logic       header_finished;

    rom_loader #(
        .hdr_window (hdr_window)
    ) u_loader (
        .clk        (clk),
        .resetn     (resetn),
        .rom_d      (rom_d),
        .rom_strb   (rom_strb),
        .rom_ready  (rom_ready),
        .load_en    (load_en),
        .hdr_base   (hdr_base),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .hdr_d      (hdr_d),
        .hdr_strb   (hdr_strb),
        .byte_count (byte_count)
    );

    header_parser #(
        .small_rom_limit (small_rom_limit)
    ) u_parser (
        .clk             (clk),
        .resetn          (resetn),
        .hdr_d           (hdr_d),
        .hdr_strb        (hdr_strb),
        .rom_type        (rom_type),
        .rom_mask        (rom_mask),
        .ram_mask        (ram_mask),
        .rom_size        (rom_size),
        .ram_size        (ram_size),
        .header_finished (header_finished)
    );

    cart_regs u_regs (
        .clk             (clk),
        .resetn          (resetn),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .load_en         (load_en),
        .hdr_base        (hdr_base),
        .byte_count      (byte_count),
        .rom_type        (rom_type),
        .rom_mask        (rom_mask),
        .ram_mask        (ram_mask),
        .rom_size        (rom_size),
        .ram_size        (ram_size),
        .header_finished (header_finished)
    );

endmodule

// File: verification/cart_loader_properties.sv
module cart_loader_properties (
    input logic                clk,
    input logic                resetn,
    input logic                rom_strb,
    input logic                rom_ready,
    input logic                mem_we,
    input logic                pwrite,
    input logic                pslverr,
    input logic                load_en,
    input cart_pkg::rom_addr_t hdr_base,
    input logic                header_finished
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Once finished, the header stays finished until the next reset
    finished_sticky: assert property (
        @(posedge clk) disable iff (!resetn) header_finished |=> header_finished
    ) else begin
        $error("header_finished fell without a reset");
        failures++;
    end

    // Every memory write comes from a byte accepted one cycle earlier
    write_follows_accept: assert property (
        @(posedge clk) disable iff (!resetn) mem_we |-> $past(rom_strb && rom_ready)
    ) else begin
        $error("mem_we without an accepted stream byte");
        failures++;
    end

    // A refused write leaves the loader setup untouched
    refused_write_ignored: assert property (
        @(posedge clk) disable iff (!resetn)
        (pslverr && pwrite) |=> ($stable(load_en) && $stable(hdr_base))
    ) else begin
        $error("a refused APB write changed the loader setup");
        failures++;
    end

endmodule

bind cart_loader_top cart_loader_properties u_props (
    .clk             (clk),
    .resetn          (resetn),
    .rom_strb        (rom_strb),
    .rom_ready       (rom_ready),
    .mem_we          (mem_we),
    .pwrite          (pwrite),
    .pslverr         (pslverr),
    .load_en         (load_en),
    .hdr_base        (hdr_base),
    .header_finished (header_finished)
);

// File: verification/cart_loader_tb.sv
module cart_loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cart_pkg::*;

    logic      clk;
    logic      resetn;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    byte_t     rom_d;
    logic      rom_strb;
    logic      rom_ready;
    logic      mem_we;
    rom_addr_t mem_addr;
    byte_t     mem_data;

    // Cartridge table, one entry per row
    string      t_name[$];
    int         t_base[$];
    byte_t      t_map[$];
    byte_t      t_type[$];
    byte_t      t_rom_size[$];
    byte_t      t_ram_size[$];
    byte_t      t_company[$];
    bit         t_pause[$];
    rom_type_t  t_exp_type[$];
    rom_addr_t  t_exp_rom_mask[$];
    rom_addr_t  t_exp_ram_mask[$];

    byte_t  image[0:1023];
    int     image_len;
    integer seed = 32'h6aa2;
    int     errors = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    int     limit = 0;
    int     writes = 0;

    cart_loader_top uut (
        .clk       (clk),
        .resetn    (resetn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rom_d     (rom_d),
        .rom_strb  (rom_strb),
        .rom_ready (rom_ready),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data)
    );

    always #4 clk = ~clk;

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Memory-side monitor, writes land in order and carry the byte sent
    always @(posedge clk) begin
        if (!resetn) begin
            writes = 0;
        end else if (mem_we) begin
            check("mem_write_addr", writes, mem_addr);
            check("mem_write_data", image[mem_addr], mem_data);
            writes++;
        end
    end

    task automatic add_row(input string name, input int base, input byte_t map,
                           input byte_t typ, input byte_t rs, input byte_t ras,
                           input byte_t company, input bit pause, input rom_type_t e_type,
                           input rom_addr_t e_rom, input rom_addr_t e_ram);
        t_name.push_back(name);
        t_base.push_back(base);
        t_map.push_back(map);
        t_type.push_back(typ);
        t_rom_size.push_back(rs);
        t_ram_size.push_back(ras);
        t_company.push_back(company);
        t_pause.push_back(pause);
        t_exp_type.push_back(e_type);
        t_exp_rom_mask.push_back(e_rom);
        t_exp_ram_mask.push_back(e_ram);
    endtask

    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready && waits < 16) begin
            waits++;
            @(posedge clk);
        end
        if (!pready) begin
            $display("APB access to %h never completed", addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
        check("apb_write_slverr", 0, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check("apb_read_slverr", 0, err);
    endtask

    // Drive bytes on falling edges, holding each until rom_ready
    task automatic send_bytes(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(negedge clk);
            rom_d    = image[i];
            rom_strb = 1'b1;
            while (!rom_ready) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        rom_strb = 1'b0;
    endtask

    task automatic run_row(input int r);
        int        base;
        int        half;
        int        err_start;
        apb_data_t rd;
        err_start = errors;
        base      = t_base[r];
        image_len = base + hdr_len + 16;
        for (int i = 0; i < image_len; i++) begin
            image[i] = $random(seed);
        end
        image[base + hdr_map_off]      = t_map[r];
        image[base + hdr_type_off]     = t_type[r];
        image[base + hdr_rom_size_off] = t_rom_size[r];
        image[base + hdr_ram_size_off] = t_ram_size[r];
        image[base + hdr_company_off]  = t_company[r];

        @(negedge clk);
        resetn   = 1'b0;
        rom_strb = 1'b0;
        repeat (16) @(negedge clk);
        resetn = 1'b1;

        apb_write(reg_hdr_base, base);
        apb_read(reg_hdr_base, rd);
        check({t_name[r], "_hdr_base"}, base, rd);
        apb_write(reg_ctrl, 1);

        half = image_len / 2;
        send_bytes(0, half - 1);
        if (t_pause[r]) begin
            apb_write(reg_ctrl, 0);
            @(negedge clk);
            rom_d    = image[half];
            rom_strb = 1'b1;
            repeat (8) begin
                @(negedge clk);
                check({t_name[r], "_ready_low"}, 0, rom_ready);
            end
            rom_strb = 1'b0;
            apb_read(reg_status, rd);
            check({t_name[r], "_frozen_count"}, half, rd[31:8]);
            apb_write(reg_ctrl, 1);
        end
        send_bytes(half, image_len - 1);

        // Poll for the finished flag
        rd = '0;
        for (int k = 0; k < 20 && !rd[0]; k++) begin
            apb_read(reg_status, rd);
        end
        if (!rd[0]) begin
            $display("Header of %s was never reported finished", t_name[r]);
            errors++;
        end
        check({t_name[r], "_byte_count"}, image_len, rd[31:8]);
        check({t_name[r], "_mem_writes"}, image_len, writes);
        apb_read(reg_info, rd);
        check({t_name[r], "_rom_type"}, t_exp_type[r], rd[7:0]);
        check({t_name[r], "_rom_size"}, t_rom_size[r][3:0], rd[11:8]);
        check({t_name[r], "_ram_size"}, t_ram_size[r][3:0], rd[15:12]);
        apb_read(reg_rom_mask, rd);
        check({t_name[r], "_rom_mask"}, t_exp_rom_mask[r], rd);
        apb_read(reg_ram_mask, rd);
        check({t_name[r], "_ram_mask"}, t_exp_ram_mask[r], rd);

        if (errors == err_start) begin
            $display("test %s: ok", t_name[r]);
        end else begin
            $display("test %s: %0d mismatches", t_name[r], errors - err_start);
            tests_failed++;
        end
    endtask

    task automatic check_apb_errors();
        apb_data_t rd;
        logic      err;
        int        err_start;
        err_start = errors;
        apb_xfer(1'b0, 8'h18, '0, rd, err);
        check("apb_bad_addr_slverr", 1, err);
        apb_xfer(1'b1, reg_status, 32'hFFFF_FFFF, rd, err);
        check("apb_ro_write_slverr", 1, err);
        if (errors == err_start) begin
            $display("test apb_errors: ok");
        end else begin
            $display("test apb_errors: %0d mismatches", errors - err_start);
            tests_failed++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        resetn   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rom_d    = '0;
        rom_strb = 1'b0;
        image_len = 0;

        //      name         base  map   type  rom   ram   comp  pause type rom_mask ram_mask
        add_row("lorom",     0,    'h20, 'h02, 'h0A, 'h03, 'h01, 0, 'h00, 'h0FFFFF, 'h001FFF);
        add_row("small_rom", 0,    'h20, 'h00, 'h07, 'h00, 'h01, 0, 'h00, 'h3FFFFF, 'h000000);
        add_row("dsp1",      0,    'h20, 'h03, 'h0A, 'h00, 'h01, 0, 'h80, 'h0FFFFF, 'h000000);
        add_row("dsp3",      0,    'h30, 'h05, 'h0A, 'h01, 'hB2, 0, 'hA0, 'h0FFFFF, 'h0007FF);
        add_row("sa1",       0,    'h23, 'h35, 'h0B, 'h05, 'h01, 0, 'h63, 'h1FFFFF, 'h007FFF);
        add_row("spc7110",   0,    'h3A, 'hF9, 'h0C, 'h03, 'h01, 0, 'hDA, 'h3FFFFF, 'h001FFF);
        add_row("st0xx",     0,    'h30, 'hF6, 'h09, 'h00, 'h01, 0, 'hA8, 'h07FFFF, 'h000000);
        add_row("cx4",       0,    'h20, 'hF3, 'h0B, 'h00, 'h01, 0, 'h40, 'h1FFFFF, 'h000000);
        add_row("gsu",       0,    'h20, 'h13, 'h0A, 'h00, 'h01, 0, 'h70, 'h0FFFFF, 'h00FFFF);
        add_row("base_40",   'h40, 'h21, 'h02, 'h0B, 'h01, 'h01, 0, 'h01, 'h1FFFFF, 'h0007FF);
        add_row("pause",     'h10, 'h21, 'h02, 'h0A, 'h02, 'h01, 1, 'h01, 'h0FFFFF, 'h000FFF);

        foreach (t_base[r]) begin
            limit += t_base[r] + hdr_len + 200;
        end

        foreach (t_name[r]) begin
            run_row(r);
        end
        check_apb_errors();

        // Assertion failures of the bound checker count as errors
        errors += uut.u_props.failures;

        $display("%0d tests, %0d failed, %0d mismatches", t_name.size() + 1,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: list.f
logic/cart_pkg.sv
logic/header_parser.sv
logic/rom_loader.sv
logic/cart_regs.sv
logic/cart_loader_top.sv
verification/cart_loader_properties.sv
verification/cart_loader_tb.sv

// File: Bender.yml
package:
  name: cart_loader

sources:
  - logic/cart_pkg.sv
  - logic/header_parser.sv
  - logic/rom_loader.sv
  - logic/cart_regs.sv
  - logic/cart_loader_top.sv
  - target: test
    files:
      - verification/cart_loader_properties.sv
      - verification/cart_loader_tb.sv
